// File: list.f
common/obj_pkg.sv
list/obj_list_reader.sv
list/obj_attr_eval.sv
render/obj_tile_shifter.sv
render/obj_draw_ctrl.sv
hdl/tc0200obj.sv
sim/tb_obj_mem.sv
sim/obj_props.sv
sim/tb_tc0200obj.sv

// File: Bender.yml
package:
  name: tc0200obj

sources:
  - common/obj_pkg.sv
  - list/obj_list_reader.sv
  - list/obj_attr_eval.sv
  - render/obj_tile_shifter.sv
  - render/obj_draw_ctrl.sv
  - hdl/tc0200obj.sv
  - target: simulation
    files:
      - sim/tb_obj_mem.sv
      - sim/obj_props.sv
      - sim/tb_tc0200obj.sv

// File: sim/tb_tc0200obj.sv
module tb_tc0200obj;
    import obj_pkg::*;

    localparam mem_addr_t tile_base = 32'h1000;
    localparam int frame_timeout = 20000;
    // word 4 bits
    localparam logic [15:0] a_flip = 16'h0100;
    localparam logic [15:0] a_reuse = 16'h0400;
    localparam logic [15:0] a_cur = 16'h5000;
    localparam logic [15:0] a_x16 = 16'h8000;
    // word 6 bits
    localparam logic [15:0] p_lextra = 16'h1000;
    localparam logic [15:0] p_lmaster = 16'h2000;
    localparam logic [15:0] p_noextra = 16'h4000;
    localparam logic [15:0] p_abs = 16'h8000;

    logic         clk;
    logic         reset;
    logic         frame_req;
    logic         frame_ack;
    logic         tile_busy;
    logic         fb_busy;
    logic         rsp_gap;
    logic         jitter;
    ra_t          ra;
    logic [15:0]  obj_data;
    tile_rd_req_t tile_req;
    tile_rd_rsp_t tile_rsp;
    fb_wr_t       fb_wr;
    logic [2:0]   busy_pat [4096];
    logic [11:0]  cyc;

    // reference model state and expected traffic
    coord_t       m_x, m_y, e_x, e_y, l_x, l_y;
    color_t       l_c;
    mem_addr_t    exp_rd [$];
    fb_addr_t     exp_addr [$];
    mem_data_t    exp_data [$];
    byte_en_t     exp_be [$];

    tc0200obj #(
        .num_objs(4),
        .tile_base(tile_base)
    ) uut (
        .clk(clk),
        .reset(reset),
        .frame_req(frame_req),
        .frame_ack(frame_ack),
        .ra(ra),
        .obj_data(obj_data),
        .tile_req(tile_req),
        .tile_busy(tile_busy),
        .tile_rsp(tile_rsp),
        .fb_wr(fb_wr),
        .fb_busy(fb_busy)
    );

    tb_obj_mem mem (
        .clk(clk),
        .ra(ra),
        .obj_data(obj_data),
        .tile_req(tile_req),
        .tile_busy(tile_busy),
        .rsp_gap(rsp_gap),
        .tile_rsp(tile_rsp),
        .fb_wr(fb_wr),
        .fb_busy(fb_busy)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc       <= cyc + 12'd1;
        fb_busy   <= jitter & busy_pat[cyc][0];
        tile_busy <= jitter & busy_pat[cyc][1];
        rsp_gap   <= jitter & busy_pat[cyc][2];
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got %h expected %h", what, got, exp));
        end
    endtask

    // pixel k of a tile in rows of 16 with eight pixels per burst word
    function automatic pix_t tile_pix(input tile_code_t code, input int k);
        mem_data_t   w;
        logic [31:0] half;
        int          i;
        w    = mem.tile_mem[int'(tile_base >> 3) + int'(code) * 32 + k / 8];
        half = (k % 8 < 4) ? w[31:0] : w[63:32];
        i    = k % 4;
        return {half[16 + 2 * i +: 2], half[4 * i +: 4]};
    endfunction

    task automatic expect_sprite(input tile_code_t code, input coord_t x, input coord_t y,
                                 input color_t color, input logic flip);
        mem_data_t data;
        byte_en_t  be;
        pix_t      pix;
        int        p;
        exp_rd.push_back(tile_base + (mem_addr_t'(code) << 8));
        for (int r = 0; r < 16; r++) begin
            for (int c = 0; c < row_words; c++) begin
                data = '0;
                be   = '0;
                for (int j = 0; j < 4; j++) begin
                    // tile column shown in this lane
                    p   = 4 * c + j - int'(x[1:0]);
                    pix = '0;
                    if (p >= 0 && p < 16) begin
                        pix = tile_pix(code, 16 * r + (flip ? 15 - p : p));
                    end
                    data[16 * j +: 16] = {4'd0, color[7:2], pix};
                    be[2 * j +: 2]     = (pix != '0) ? 2'b11 : 2'b00;
                end
                exp_addr.push_back(fb_addr_t'({y[7:0], x[8:2]}) + fb_addr_t'(128 * r + c));
                exp_data.push_back(data);
                exp_be.push_back(be);
            end
        end
    endtask

    task automatic model_entry(input logic [15:0] w0, input logic [15:0] w4,
                               input logic [15:0] w6, input logic [15:0] w7);
        coord_t sx, sy, bx, by, nx, ny;
        color_t nc;
        sx = '0;
        sy = '0;
        if (!w6[15]) begin
            sx = m_x + (w6[14] ? 12'd0 : e_x);
            sy = m_y + (w6[14] ? 12'd0 : e_y);
        end
        bx = w6[11:0] + sx;
        by = w7[11:0] + sy;
        if (w6[12]) begin
            e_x = bx;
            e_y = by;
        end
        if (w6[13]) begin
            m_x = bx;
            m_y = by;
        end
        nx  = (w4[14] ? bx : l_x) + (w4[15] ? 12'd16 : 12'd0);
        ny  = (w4[12] ? by : l_y) + (w4[13] ? 12'd16 : 12'd0);
        nc  = w4[10] ? l_c : w4[7:0];
        l_x = nx;
        l_y = ny;
        l_c = nc;
        if (w0[13:0] != 0 && nx <= coord_t'(x_limit) && ny <= coord_t'(y_limit)) begin
            expect_sprite(w0[13:0], nx, ny, nc, w4[8]);
        end
    endtask

    task automatic put_entry(input int idx, input logic [15:0] w0, input logic [15:0] w4,
                             input logic [15:0] w6, input logic [15:0] w7);
        // unused words get noise
        for (int k = 0; k < 8; k++) begin
            mem.obj_ram[8 * idx + k] = 16'($urandom);
        end
        mem.obj_ram[8 * idx]     = w0;
        mem.obj_ram[8 * idx + 4] = w4;
        mem.obj_ram[8 * idx + 6] = w6;
        mem.obj_ram[8 * idx + 7] = w7;
        model_entry(w0, w4, w6, w7);
    endtask

    task automatic put_blank(input int idx);
        put_entry(idx, 16'h0, a_cur, p_abs, 16'h0);
    endtask

    task automatic clear_traffic();
        exp_rd.delete();
        exp_addr.delete();
        exp_data.delete();
        exp_be.delete();
        mem.rd_addr_q.delete();
        mem.wr_addr_q.delete();
        mem.wr_data_q.delete();
        mem.wr_be_q.delete();
    endtask

    task automatic compare_traffic();
        check_value("tile read count", mem.rd_addr_q.size(), exp_rd.size());
        foreach (exp_rd[i]) begin
            check_value($sformatf("tile_req.addr (read %0d)", i), mem.rd_addr_q[i], exp_rd[i]);
        end
        check_value("fb write count", mem.wr_addr_q.size(), exp_addr.size());
        foreach (exp_addr[i]) begin
            check_value($sformatf("fb_wr.addr (write %0d)", i), mem.wr_addr_q[i], exp_addr[i]);
            check_value($sformatf("fb_wr.data (write %0d)", i), mem.wr_data_q[i], exp_data[i]);
            check_value($sformatf("fb_wr.be (write %0d)", i), mem.wr_be_q[i], exp_be[i]);
        end
    endtask

    task automatic run_frame();
        int cycles;
        @(posedge clk);
        frame_req <= 1'b1;
        cycles = 0;
        while (frame_ack !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > frame_timeout) begin
                stop_on_error("timeout while waiting for frame_ack to rise");
            end
        end
        frame_req <= 1'b0;
        cycles = 0;
        while (frame_ack !== 1'b0) begin
            @(posedge clk);
            cycles++;
            if (cycles > frame_timeout) begin
                stop_on_error("timeout while waiting for frame_ack to fall");
            end
        end
        compare_traffic();
    endtask

    task automatic load_single_sprite();
        put_entry(0, 16'd1, a_cur | 16'h005c, p_abs | 16'd40, 16'd20);
        put_blank(1);
        put_blank(2);
        put_blank(3);
    endtask

    task automatic test_single_sprite();
        clear_traffic();
        load_single_sprite();
        run_frame();
    endtask

    task automatic test_flip_shift();
        clear_traffic();
        put_entry(0, 16'd2, a_cur | a_flip | 16'h00a7, p_abs | 16'd103, 16'd50);
        put_blank(1);
        put_blank(2);
        put_blank(3);
        run_frame();
    endtask

    task automatic test_scroll_latch();
        clear_traffic();
        put_entry(0, 16'd0, a_cur, p_abs | p_lmaster | 16'd16, 16'd8);
        put_entry(1, 16'd3, a_cur | 16'h0091, p_noextra | 16'd30, 16'd12);
        put_entry(2, 16'd0, a_cur, p_abs | p_lextra | 16'd4, 16'd6);
        put_entry(3, 16'd4, a_cur | 16'h002d, 16'd50, 16'd40);
        run_frame();
    endtask

    task automatic test_skipped_entries();
        clear_traffic();
        put_entry(0, 16'd0, a_cur | 16'h0011, p_abs | 16'd10, 16'd10);
        put_entry(1, 16'd5, a_cur | 16'h0022, p_abs | 16'd20, 16'd241);
        put_entry(2, 16'd6, a_cur | 16'h0033, p_abs | 16'd481, 16'd20);
        put_blank(3);
        run_frame();
    endtask

    task automatic test_latched_position();
        clear_traffic();
        // master scroll only, the extra scroll latched earlier stays out
        put_entry(0, 16'd7, a_cur | 16'h003e, p_noextra | 16'd184, 16'd92);
        put_entry(1, 16'd1, a_x16 | a_reuse | 16'h00ff, p_abs, 16'd0);
        put_blank(2);
        put_blank(3);
        run_frame();
    endtask

    task automatic test_busy_patterns();
        @(posedge clk);
        jitter <= 1'b1;
        clear_traffic();
        load_single_sprite();
        run_frame();
        jitter <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'h6a53));
        clk       = 1'b0;
        reset     = 1'b1;
        frame_req = 1'b0;
        tile_busy = 1'b0;
        fb_busy   = 1'b0;
        rsp_gap   = 1'b0;
        jitter    = 1'b0;
        cyc       = '0;
        m_x       = '0;
        m_y       = '0;
        e_x       = '0;
        e_y       = '0;
        l_x       = '0;
        l_y       = '0;
        l_c       = '0;
        for (int i = 0; i < 4096; i++) begin
            busy_pat[i] = 3'($urandom);
        end
        // sparse bits so some pixels come out transparent
        for (int i = 0; i < 1024; i++) begin
            mem.tile_mem[i] = {$urandom, $urandom} & {$urandom, $urandom};
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);

        test_single_sprite();
        test_flip_shift();
        test_scroll_latch();
        test_skipped_entries();
        test_latched_position();
        test_busy_patterns();

        repeat (4) @(posedge clk);
        if (uut.props.fail_count != 0) begin
            stop_on_error("an assertion on the DUT ports failed");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// File: sim/obj_props.sv
module obj_props (
    input logic                  clk,
    input logic                  reset,
    input logic                  frame_req,
    input logic                  frame_ack,
    input obj_pkg::tile_rd_req_t tile_req,
    input logic                  tile_busy,
    input obj_pkg::fb_wr_t       fb_wr,
    input logic                  fb_busy
);
    int fail_count = 0;

    // a stalled write keeps every field until it is taken
    fb_hold: assert property (@(posedge clk) disable iff (reset)
        fb_wr.wr && fb_busy |=> fb_wr.wr && $stable(fb_wr))
    else begin
        fail_count++;
        $error("fb write changed while fb_busy was high");
    end

    tile_hold: assert property (@(posedge clk) disable iff (reset)
        tile_req.rd && tile_busy |=> tile_req.rd && $stable(tile_req))
    else begin
        fail_count++;
        $error("tile read request changed while tile_busy was high");
    end

    // four-phase frame handshake
    ack_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(frame_ack) |-> $past(!frame_req))
    else begin
        fail_count++;
        $error("frame_ack fell while frame_req was still high");
    end

    ack_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(frame_ack) |-> $past(frame_req))
    else begin
        fail_count++;
        $error("frame_ack rose without frame_req");
    end

    reset_quiet: assert property (@(posedge clk)
        reset |=> !frame_ack && !fb_wr.wr && !tile_req.rd)
    else begin
        fail_count++;
        $error("strobes not low after reset");
    end

endmodule

bind tc0200obj obj_props props (
    .clk(clk),
    .reset(reset),
    .frame_req(frame_req),
    .frame_ack(frame_ack),
    .tile_req(tile_req),
    .tile_busy(tile_busy),
    .fb_wr(fb_wr),
    .fb_busy(fb_busy)
);

// File: sim/tb_obj_mem.sv
module tb_obj_mem (
    input  logic                  clk,
    input  obj_pkg::ra_t          ra,
    output logic [15:0]           obj_data,
    input  obj_pkg::tile_rd_req_t tile_req,
    input  logic                  tile_busy,
    input  logic                  rsp_gap,
    output obj_pkg::tile_rd_rsp_t tile_rsp,
    input  obj_pkg::fb_wr_t       fb_wr,
    input  logic                  fb_busy
);
    import obj_pkg::*;

    logic [15:0] obj_ram [256];
    mem_data_t   tile_mem [1024];
    logic [9:0]  burst_ptr;
    int          burst_left;

    // accepted tile reads and framebuffer writes, in order
    mem_addr_t   rd_addr_q [$];
    fb_addr_t    wr_addr_q [$];
    mem_data_t   wr_data_q [$];
    byte_en_t    wr_be_q [$];

    initial begin
        obj_data   = '0;
        tile_rsp   = '0;
        burst_ptr  = '0;
        burst_left = 0;
        for (int i = 0; i < 256; i++) begin
            obj_ram[i] = '0;
        end
    end

    // synchronous object RAM
    always @(posedge clk) begin
        obj_data <= obj_ram[ra[7:0]];
    end

    // burst reply, a word per cycle unless a gap is asked for
    always @(posedge clk) begin
        tile_rsp.valid <= 1'b0;
        if (burst_left > 0 && !rsp_gap) begin
            tile_rsp.valid <= 1'b1;
            tile_rsp.data  <= tile_mem[burst_ptr];
            burst_ptr      <= burst_ptr + 10'd1;
            burst_left     <= burst_left - 1;
        end
        if (tile_req.rd && !tile_busy && burst_left == 0) begin
            rd_addr_q.push_back(tile_req.addr);
            burst_ptr  <= tile_req.addr[12:3];
            burst_left <= int'(tile_req.burst_cnt);
        end
    end

    always @(posedge clk) begin
        if (fb_wr.wr && !fb_busy) begin
            wr_addr_q.push_back(fb_wr.addr);
            wr_data_q.push_back(fb_wr.data);
            wr_be_q.push_back(fb_wr.be);
        end
    end

endmodule

// File: hdl/tc0200obj.sv
module tc0200obj #(
    parameter int                 num_objs  = 835,
    parameter obj_pkg::mem_addr_t tile_base = 32'h0
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  frame_req,
    output logic                  frame_ack,

    output obj_pkg::ra_t          ra,
    input  logic [15:0]           obj_data,

    output obj_pkg::tile_rd_req_t tile_req,
    input  logic                  tile_busy,
    input  obj_pkg::tile_rd_rsp_t tile_rsp,

    output obj_pkg::fb_wr_t       fb_wr,
    input  logic                  fb_busy
);
    import obj_pkg::*;

    obj_entry_t entry;
    logic       entry_valid;
    logic       entry_ready;

    draw_job_t  job;
    logic       job_valid;
    logic       job_ready;

    logic       eval_busy;
    logic       draw_idle;
    logic       pipe_idle;

    // nothing left in the evaluator or the draw stage
    assign pipe_idle = draw_idle & ~eval_busy;

    obj_list_reader #(
        .num_objs(num_objs)
    ) u_list_reader (
        .clk(clk),
        .reset(reset),
        .frame_req(frame_req),
        .obj_data(obj_data),
        .entry_ready(entry_ready),
        .draw_idle(pipe_idle),
        .frame_ack(frame_ack),
        .ra(ra),
        .entry(entry),
        .entry_valid(entry_valid)
    );

    obj_attr_eval u_attr_eval (
        .clk(clk),
        .reset(reset),
        .entry(entry),
        .entry_valid(entry_valid),
        .job_ready(job_ready),
        .entry_ready(entry_ready),
        .job(job),
        .job_valid(job_valid),
        .busy(eval_busy)
    );

    obj_draw_ctrl #(
        .tile_base(tile_base)
    ) u_draw_ctrl (
        .clk(clk),
        .reset(reset),
        .job(job),
        .job_valid(job_valid),
        .tile_busy(tile_busy),
        .tile_rsp(tile_rsp),
        .fb_busy(fb_busy),
        .job_ready(job_ready),
        .tile_req(tile_req),
        .fb_wr(fb_wr),
        .idle(draw_idle)
    );

endmodule

// File: render/obj_draw_ctrl.sv
module obj_draw_ctrl #(
    parameter obj_pkg::mem_addr_t tile_base = 32'h0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  obj_pkg::draw_job_t    job,
    input  logic                  job_valid,
    input  logic                  tile_busy,
    input  obj_pkg::tile_rd_rsp_t tile_rsp,
    input  logic                  fb_busy,
    output logic                  job_ready,
    output obj_pkg::tile_rd_req_t tile_req,
    output obj_pkg::fb_wr_t       fb_wr,
    output logic                  idle
);
    import obj_pkg::*;

    draw_state_t state;
    logic        rd_strobe;
    mem_addr_t   rd_addr;

    logic        start;
    logic        load;
    logic        advance;
    logic        loaded;
    logic        word_valid;
    mem_data_t   word_data;
    byte_en_t    word_be;
    fb_addr_t    word_addr;
    logic        last;

    assign start   = (state == dr_idle) && job_valid;
    assign load    = tile_rsp.valid && (state == dr_read_tile || state == dr_wait_burst);
    assign advance = fb_wr.wr && !fb_busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= dr_idle;
            rd_strobe <= 1'b0;
        end else begin
            case (state)
                dr_idle: begin
                    if (job_valid) begin
                        rd_strobe <= 1'b1;
                        state     <= dr_read_tile;
                    end
                end
                dr_read_tile: begin
                    // request taken on a cycle without busy
                    if (!tile_busy) begin
                        rd_strobe <= 1'b0;
                        state     <= dr_wait_burst;
                    end
                end
                dr_wait_burst: begin
                    if (loaded) begin
                        state <= dr_draw;
                    end
                end
                dr_draw: begin
                    if (advance && last) begin
                        state <= dr_idle;
                    end
                end
                default: state <= dr_idle;
            endcase
        end
    end

    // 256 bytes per 6 bpp tile
    always_ff @(posedge clk) begin
        if (start) begin
            rd_addr <= tile_base + (mem_addr_t'(job.tile_code) << 8);
        end
    end

    assign tile_req.rd        = rd_strobe;
    assign tile_req.addr      = rd_addr;
    assign tile_req.burst_cnt = 8'(tile_burst_len);

    obj_tile_shifter u_shifter (
        .clk(clk),
        .reset(reset),
        .start(start),
        .job(job),
        .load(load),
        .din(tile_rsp.data),
        .advance(advance),
        .loaded(loaded),
        .word_valid(word_valid),
        .word_data(word_data),
        .word_be(word_be),
        .word_addr(word_addr),
        .last(last)
    );

    assign fb_wr.wr   = (state == dr_draw) && word_valid;
    assign fb_wr.addr = word_addr;
    assign fb_wr.data = word_data;
    assign fb_wr.be   = word_be;

    assign job_ready = (state == dr_idle);
    assign idle      = (state == dr_idle);

endmodule

// File: render/obj_tile_shifter.sv
module obj_tile_shifter (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  obj_pkg::draw_job_t job,
    input  logic               load,
    input  obj_pkg::mem_data_t din,
    input  logic               advance,
    output logic               loaded,
    output logic               word_valid,
    output obj_pkg::mem_data_t word_data,
    output obj_pkg::byte_en_t  word_be,
    output obj_pkg::fb_addr_t  word_addr,
    output logic               last
);
    import obj_pkg::*;

    // four 6 bpp pixels per 32-bit half word
    function automatic logic [23:0] decode_half(input logic [31:0] d);
        logic [23:0] r;
        for (int i = 0; i < 4; i++) begin
            r[6*i +: 6] = {d[16 + 2*i +: 2], d[4*i +: 4]};
        end
        return r;
    endfunction

    draw_job_t   job_q;
    pix_t        pixel [256];
    pix_t        row_win [20];
    pix_t        win_next [20];

    logic [4:0]  burst_idx;
    logic [3:0]  row;
    logic [2:0]  col;
    logic [3:0]  win_row;
    logic [23:0] dec_lo;
    logic [23:0] dec_hi;
    logic        last_load;
    logic        row_done;

    assign dec_lo    = decode_half(din[31:0]);
    assign dec_hi    = decode_half(din[63:32]);
    assign last_load = load && (burst_idx == 5'(tile_burst_len - 1));
    assign row_done  = advance && word_valid && (col == 3'(row_words - 1));

    // row 0 right after the burst, then the row after the current one
    assign win_row = loaded ? row + 4'd1 : 4'd0;

    always_comb begin
        win_next = '{default: '0};
        for (int i = 0; i < 16; i++) begin
            win_next[i + job_q.x[1:0]] = pixel[{win_row, job_q.x_flip ? 4'(15 - i) : 4'(i)}];
        end
    end

    always_ff @(posedge clk) begin
        if (reset || start) begin
            burst_idx  <= '0;
            loaded     <= 1'b0;
            word_valid <= 1'b0;
            row        <= '0;
            col        <= '0;
        end else begin
            if (load) begin
                burst_idx <= burst_idx + 5'd1;
            end
            if (last_load) begin
                loaded     <= 1'b1;
                word_valid <= 1'b1;
            end
            if (advance && word_valid) begin
                if (row_done) begin
                    col <= '0;
                    row <= row + 4'd1;
                    if (row == 4'd15) begin
                        word_valid <= 1'b0;
                    end
                end else begin
                    col <= col + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            job_q <= job;
        end
        if (load) begin
            for (int j = 0; j < 4; j++) begin
                pixel[{burst_idx, 3'(j)}]     <= dec_lo[6*j +: 6];
                pixel[{burst_idx, 3'(j + 4)}] <= dec_hi[6*j +: 6];
            end
        end
        if (last_load || row_done) begin
            row_win <= win_next;
        end
    end

    // one 16-bit lane per pixel, transparent pixels masked
    always_comb begin
        word_data = '0;
        word_be   = '0;
        for (int j = 0; j < 4; j++) begin
            word_data[16*j +: 16] = {4'd0, job_q.color[7:2], row_win[4*col + j]};
            word_be[2*j +: 2]     = {2{|row_win[4*col + j]}};
        end
    end

    assign word_addr = fb_addr_t'({job_q.y[7:0], job_q.x[8:2]}) + fb_addr_t'({row, 7'd0})
        + fb_addr_t'(col);
    assign last = word_valid && (row == 4'd15) && (col == 3'(row_words - 1));

endmodule

// File: list/obj_attr_eval.sv
module obj_attr_eval (
    input  logic                clk,
    input  logic                reset,
    input  obj_pkg::obj_entry_t entry,
    input  logic                entry_valid,
    input  logic                job_ready,
    output logic                entry_ready,
    output obj_pkg::draw_job_t  job,
    output logic                job_valid,
    output logic                busy
);
    import obj_pkg::*;

    obj_entry_t cur;
    logic       have_entry;

    coord_t master_x, master_y;
    coord_t extra_x, extra_y;
    coord_t latch_x, latch_y;
    color_t latch_color;

    coord_t scroll_x, scroll_y;
    coord_t base_x, base_y;
    coord_t next_x, next_y;
    color_t next_color;
    logic   visible;

    always_comb begin
        scroll_x = '0;
        scroll_y = '0;
        // extra scroll only applies on top of the master scroll
        if (!cur.absolute) begin
            scroll_x = master_x;
            scroll_y = master_y;
            if (!cur.no_extra) begin
                scroll_x = master_x + extra_x;
                scroll_y = master_y + extra_y;
            end
        end
        base_x = cur.x_coord + scroll_x;
        base_y = cur.y_coord + scroll_y;

        // clear use_cur bit continues from the previous sprite
        next_x = (cur.use_cur_x ? base_x : latch_x) + (cur.x_plus16 ? coord_t'(16) : coord_t'(0));
        next_y = (cur.use_cur_y ? base_y : latch_y) + (cur.y_plus16 ? coord_t'(16) : coord_t'(0));
        next_color = cur.reuse_color ? latch_color : cur.color;

        visible = (cur.tile_code != '0) && (next_x <= coord_t'(x_limit))
            && (next_y <= coord_t'(y_limit));
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            have_entry  <= 1'b0;
            job_valid   <= 1'b0;
            master_x    <= '0;
            master_y    <= '0;
            extra_x     <= '0;
            extra_y     <= '0;
            latch_x     <= '0;
            latch_y     <= '0;
            latch_color <= '0;
        end else begin
            if (entry_valid && entry_ready) begin
                have_entry <= 1'b1;
            end
            if (job_valid && job_ready) begin
                job_valid <= 1'b0;
            end
            if (have_entry) begin
                have_entry <= 1'b0;
                if (cur.latch_extra) begin
                    extra_x <= base_x;
                    extra_y <= base_y;
                end
                if (cur.latch_master) begin
                    master_x <= base_x;
                    master_y <= base_y;
                end
                latch_x     <= next_x;
                latch_y     <= next_y;
                latch_color <= next_color;
                // skipped entries still update the latches
                if (visible) begin
                    job_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (entry_valid && entry_ready) begin
            cur <= entry;
        end
        if (have_entry && visible) begin
            job.tile_code <= cur.tile_code;
            job.x         <= next_x;
            job.y         <= next_y;
            job.color     <= next_color;
            job.x_flip    <= cur.x_flip;
        end
    end

    assign entry_ready = !have_entry && !job_valid;
    assign busy        = have_entry || job_valid;

endmodule

// File: list/obj_list_reader.sv
module obj_list_reader #(
    parameter int num_objs = 835
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                frame_req,
    input  logic [15:0]         obj_data,
    input  logic                entry_ready,
    input  logic                draw_idle,
    output logic                frame_ack,
    output obj_pkg::ra_t        ra,
    output obj_pkg::obj_entry_t entry,
    output logic                entry_valid
);
    import obj_pkg::*;

    list_state_t state;
    logic [3:0]  word_cnt;
    logic [15:0] words [8];

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ls_idle;
            ra        <= '0;
            word_cnt  <= '0;
            frame_ack <= 1'b0;
        end else begin
            case (state)
                ls_idle: begin
                    if (frame_req) begin
                        ra       <= '0;
                        word_cnt <= '0;
                        state    <= ls_read;
                    end
                end
                ls_read: begin
                    // address leads the data by one cycle
                    if (word_cnt < 4'd8) begin
                        ra <= ra + 15'd1;
                    end else begin
                        state <= ls_offer;
                    end
                    word_cnt <= word_cnt + 4'd1;
                end
                ls_offer: begin
                    if (entry_ready) begin
                        word_cnt <= '0;
                        // ra already points at the next entry
                        if (ra[14:3] == 12'(num_objs)) begin
                            state <= ls_finish;
                        end else begin
                            state <= ls_read;
                        end
                    end
                end
                ls_finish: begin
                    if (!frame_ack && draw_idle) begin
                        frame_ack <= 1'b1;
                    end
                    if (frame_ack && !frame_req) begin
                        frame_ack <= 1'b0;
                        state     <= ls_idle;
                    end
                end
                default: state <= ls_idle;
            endcase
        end
    end

    // word n arrives while word_cnt is n + 1
    always_ff @(posedge clk) begin
        if (state == ls_read && word_cnt != 4'd0) begin
            words[3'(word_cnt - 4'd1)] <= obj_data;
        end
    end

    assign entry_valid = (state == ls_offer);

    assign entry.tile_code    = words[0][13:0];
    assign entry.x_coord      = words[6][11:0];
    assign entry.latch_extra  = words[6][12];
    assign entry.latch_master = words[6][13];
    assign entry.no_extra     = words[6][14];
    assign entry.absolute     = words[6][15];
    assign entry.y_coord      = words[7][11:0];
    assign entry.color        = words[4][7:0];
    assign entry.x_flip       = words[4][8];
    assign entry.reuse_color  = words[4][10];
    assign entry.use_cur_y    = words[4][12];
    assign entry.y_plus16     = words[4][13];
    assign entry.use_cur_x    = words[4][14];
    assign entry.x_plus16     = words[4][15];

endmodule

// File: common/obj_pkg.sv
package obj_pkg;

    // widths that carry a meaning
    typedef logic [11:0] coord_t;
    typedef logic [13:0] tile_code_t;
    typedef logic [7:0]  color_t;
    typedef logic [5:0]  pix_t;
    typedef logic [14:0] ra_t;
    // latched y[7:0] above word column x[8:2]
    typedef logic [14:0] fb_addr_t;
    typedef logic [31:0] mem_addr_t;
    typedef logic [63:0] mem_data_t;
    typedef logic [7:0]  byte_en_t;

    localparam int tile_burst_len = 32;
    localparam int row_words = 5;
    localparam int x_limit = 480;
    localparam int y_limit = 240;

    // decoded object RAM entry, words 0, 4, 6 and 7
    typedef struct packed {
        tile_code_t tile_code;
        coord_t     x_coord;
        logic       latch_extra;
        logic       latch_master;
        logic       no_extra;
        logic       absolute;
        coord_t     y_coord;
        color_t     color;
        logic       x_flip;
        logic       reuse_color;
        logic       use_cur_y;
        logic       y_plus16;
        logic       use_cur_x;
        logic       x_plus16;
    } obj_entry_t;

    typedef struct packed {
        tile_code_t tile_code;
        coord_t     x;
        coord_t     y;
        color_t     color;
        logic       x_flip;
    } draw_job_t;

    typedef struct packed {
        logic       rd;
        mem_addr_t  addr;
        logic [7:0] burst_cnt;
    } tile_rd_req_t;

    typedef struct packed {
        logic      valid;
        mem_data_t data;
    } tile_rd_rsp_t;

    typedef struct packed {
        logic      wr;
        fb_addr_t  addr;
        mem_data_t data;
        byte_en_t  be;
    } fb_wr_t;

    typedef enum logic [1:0] {
        ls_idle,
        ls_read,
        ls_offer,
        ls_finish
    } list_state_t;

    typedef enum logic [1:0] {
        dr_idle,
        dr_read_tile,
        dr_wait_burst,
        dr_draw
    } draw_state_t;

endpackage
